// File: source/battleship_pkg.sv
package battleship_pkg;

	////////////////////////////////////////
	// Board cells and coordinates
	////////////////////////////////////////

	// Committed cells use blank, ship, hit and miss only
	typedef enum logic [2:0] {
		CELL_BLANK   = 3'd0,
		CELL_SHIP    = 3'd1,
		CELL_ACTIVE  = 3'd2,
		CELL_OVERLAP = 3'd3,
		CELL_HIT     = 3'd4,
		CELL_MISS    = 3'd5
	} cell_t;

	typedef logic [3:0] coord_t;

	typedef enum logic {
		MODE_PLACE  = 1'b0,
		MODE_BATTLE = 1'b1
	} mode_t;

	typedef logic [2:0] ship_len_t;
	typedef logic [2:0] ship_cnt_t;

	// Anchor is the top or left end of the ship
	typedef struct packed {
		coord_t    row;
		coord_t    col;
		logic      vertical;
		ship_len_t len;
	} ship_pos_t;

	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
	} move_cmd_t;

	////////////////////////////////////////
	// Fleet
	////////////////////////////////////////

	localparam int SHIPS_PER_PLAYER = 5;
	localparam int MAX_SHIP_LEN = 5;
	localparam int DEFAULT_BOARD_DIM = 10;

	// Index 0 is the first ship placed
	localparam ship_len_t [SHIPS_PER_PLAYER-1:0] SHIP_LENGTHS = {3'd2, 3'd3, 3'd3, 3'd4, 3'd5};

	// Board index of cell k along a ship
	function automatic int ship_cell_index(ship_pos_t pos, int k, int dim);
		int row;
		int col;
		row = int'(pos.row);
		col = int'(pos.col);
		if (pos.vertical)
			row = row + k;
		else
			col = col + k;
		return row * dim + col;
	endfunction

endpackage

// File: source/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl #(
	parameter int BOARD_DIM = battleship_pkg::DEFAULT_BOARD_DIM
) (
	input  logic                  btnC,
	input  logic                  rst_n_i,
	input  logic                  place_i,
	input  logic                  fire_i,
	input  logic [7:0]            target_i,
	input  logic                  overlap_i,
	output logic                  commit_o,
	output logic                  strike_o,
	output logic [2:0]            ship_idx_o,
	output logic                  turn_o,
	output battleship_pkg::mode_t mode_o
);

	battleship_pkg::mode_t mode_q;
	battleship_pkg::mode_t mode_d;
	logic [2:0]            ship_idx_q;
	logic [2:0]            ship_idx_d;
	logic                  turn_q;
	logic                  turn_d;
	logic                  target_on_board;
	logic                  last_ship;

	assign target_on_board = (int'(target_i[7:4]) < BOARD_DIM) &&
		(int'(target_i[3:0]) < BOARD_DIM);
	assign last_ship = (int'(ship_idx_q) == battleship_pkg::SHIPS_PER_PLAYER - 1);

	////////////////////////////////////////
	// Strobe acceptance
	////////////////////////////////////////

	// Fire only counts in battle and place only in placement
	assign commit_o = (mode_q == battleship_pkg::MODE_PLACE) && place_i && !overlap_i;
	assign strike_o = (mode_q == battleship_pkg::MODE_BATTLE) && fire_i && target_on_board;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb begin
		mode_d = mode_q;
		ship_idx_d = ship_idx_q;
		turn_d = turn_q;
		case (mode_q)
			battleship_pkg::MODE_PLACE: begin
				if (commit_o) begin
					if (last_ship) begin
						ship_idx_d = 3'd0;
						// Player 2 done, player 1 opens the battle
						if (turn_q) begin
							mode_d = battleship_pkg::MODE_BATTLE;
							turn_d = 1'b0;
						end else begin
							turn_d = 1'b1;
						end
					end else begin
						ship_idx_d = ship_idx_q + 3'd1;
					end
				end
			end
			battleship_pkg::MODE_BATTLE: begin
				if (strike_o)
					turn_d = ~turn_q;
			end
			default: mode_d = battleship_pkg::MODE_PLACE;
		endcase
	end

	always_ff @(posedge btnC) begin
		if (!rst_n_i) begin
			mode_q <= battleship_pkg::MODE_PLACE;
			ship_idx_q <= 3'd0;
			turn_q <= 1'b0;
		end else begin
			mode_q <= mode_d;
			ship_idx_q <= ship_idx_d;
			turn_q <= turn_d;
		end
	end

	assign ship_idx_o = ship_idx_q;
	assign turn_o = turn_q;
	assign mode_o = mode_q;

endmodule

// File: source/ship_cursor.sv
`timescale 1ns/1ps

module ship_cursor #(
	parameter int BOARD_DIM = battleship_pkg::DEFAULT_BOARD_DIM
) (
	input  logic                      btnC,
	input  logic                      rst_n_i,
	input  battleship_pkg::move_cmd_t move_i,
	input  logic                      orient_i,
	input  logic                      commit_i,
	input  logic [2:0]                ship_idx_i,
	input  battleship_pkg::mode_t     mode_i,
	output battleship_pkg::ship_pos_t cursor_pos_o
);

	localparam logic [4:0] DIM = 5'(BOARD_DIM);

	battleship_pkg::ship_pos_t pos_q;
	logic [2:0]                next_idx;
	logic [4:0]                span_row;
	logic [4:0]                span_col;
	logic [4:0]                len_ext;
	logic                      placing;
	logic                      rotate;
	logic                      can_left;
	logic                      can_right;
	logic                      can_up;
	logic                      can_down;

	// Ship that follows a commit, wrapping to the next player's first
	assign next_idx = (int'(ship_idx_i) == battleship_pkg::SHIPS_PER_PLAYER - 1) ?
		3'd0 : ship_idx_i + 3'd1;

	assign len_ext = {2'b00, pos_q.len};
	assign span_row = pos_q.vertical ? len_ext : 5'd1;
	assign span_col = pos_q.vertical ? 5'd1 : len_ext;

	// Every cell must stay on the board after a move
	assign can_left = (pos_q.col != 4'd0);
	assign can_right = ({1'b0, pos_q.col} + span_col) < DIM;
	assign can_up = (pos_q.row != 4'd0);
	assign can_down = ({1'b0, pos_q.row} + span_row) < DIM;

	assign placing = (mode_i == battleship_pkg::MODE_PLACE);
	assign rotate = placing && (orient_i != pos_q.vertical);

	always_ff @(posedge btnC) begin
		if (!rst_n_i) begin
			pos_q.row <= 4'd0;
			pos_q.col <= 4'd0;
			pos_q.vertical <= orient_i;
			pos_q.len <= battleship_pkg::SHIP_LENGTHS[0];
		end else if (commit_i) begin
			// Respawn at the corner with the next length
			pos_q.row <= 4'd0;
			pos_q.col <= 4'd0;
			pos_q.vertical <= orient_i;
			pos_q.len <= battleship_pkg::SHIP_LENGTHS[next_idx];
		end else if (rotate) begin
			pos_q.vertical <= orient_i;
			// Pull the anchor back when the turned ship would overhang
			if (orient_i) begin
				if (({1'b0, pos_q.row} + len_ext) > DIM)
					pos_q.row <= battleship_pkg::coord_t'(DIM - len_ext);
			end else begin
				if (({1'b0, pos_q.col} + len_ext) > DIM)
					pos_q.col <= battleship_pkg::coord_t'(DIM - len_ext);
			end
		end else if (placing) begin
			if (move_i.left && can_left)
				pos_q.col <= pos_q.col - 4'd1;
			else if (move_i.right && can_right)
				pos_q.col <= pos_q.col + 4'd1;
			if (move_i.up && can_up)
				pos_q.row <= pos_q.row - 4'd1;
			else if (move_i.down && can_down)
				pos_q.row <= pos_q.row + 4'd1;
		end
	end

	assign cursor_pos_o = pos_q;

endmodule

// File: source/board_store.sv
`timescale 1ns/1ps

module board_store #(
	parameter int BOARD_DIM = battleship_pkg::DEFAULT_BOARD_DIM
) (
	input  logic                                           btnC,
	input  logic                                           rst_n_i,
	input  battleship_pkg::ship_pos_t                      cursor_pos_i,
	input  logic                                           commit_i,
	input  logic                                           strike_i,
	input  logic [7:0]                                     target_i,
	input  logic                                           turn_i,
	input  battleship_pkg::mode_t                          mode_i,
	output logic                                           overlap_o,
	output battleship_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0] p1_board_o,
	output battleship_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0] p2_board_o
);

	localparam int CELLS = BOARD_DIM * BOARD_DIM;

	typedef battleship_pkg::cell_t [CELLS-1:0] board_t;

	board_t           p1_q;
	board_t           p2_q;
	board_t           place_board;
	logic [CELLS-1:0] cur_mask;
	int               tgt_idx;

	// Cursor drawn over a committed cell
	function automatic battleship_pkg::cell_t overlay(battleship_pkg::cell_t base);
		return (base == battleship_pkg::CELL_SHIP) ?
			battleship_pkg::CELL_OVERLAP : battleship_pkg::CELL_ACTIVE;
	endfunction

	// Hit and miss cells keep their state
	function automatic battleship_pkg::cell_t struck(battleship_pkg::cell_t base);
		case (base)
			battleship_pkg::CELL_SHIP:  return battleship_pkg::CELL_HIT;
			battleship_pkg::CELL_BLANK: return battleship_pkg::CELL_MISS;
			default:                    return base;
		endcase
	endfunction

	////////////////////////////////////////
	// Cursor footprint and overlap
	////////////////////////////////////////

	always_comb begin
		int idx;
		idx = 0;
		cur_mask = '0;
		for (int k = 0; k < battleship_pkg::MAX_SHIP_LEN; k++) begin
			idx = battleship_pkg::ship_cell_index(cursor_pos_i, k, BOARD_DIM);
			if (k < int'(cursor_pos_i.len) && idx < CELLS)
				cur_mask[idx] = 1'b1;
		end
	end

	assign place_board = turn_i ? p2_q : p1_q;

	always_comb begin
		overlap_o = 1'b0;
		for (int i = 0; i < CELLS; i++) begin
			if (cur_mask[i] && place_board[i] == battleship_pkg::CELL_SHIP)
				overlap_o = 1'b1;
		end
	end

	////////////////////////////////////////
	// Committed boards
	////////////////////////////////////////

	assign tgt_idx = int'(target_i[7:4]) * BOARD_DIM + int'(target_i[3:0]);

	always_ff @(posedge btnC) begin
		if (!rst_n_i) begin
			for (int i = 0; i < CELLS; i++) begin
				p1_q[i] <= battleship_pkg::CELL_BLANK;
				p2_q[i] <= battleship_pkg::CELL_BLANK;
			end
		end else begin
			for (int i = 0; i < CELLS; i++) begin
				if (commit_i && cur_mask[i]) begin
					if (turn_i)
						p2_q[i] <= battleship_pkg::CELL_SHIP;
					else
						p1_q[i] <= battleship_pkg::CELL_SHIP;
				end
			end
			// The player on turn fires at the other board
			if (strike_i) begin
				if (turn_i)
					p1_q[tgt_idx] <= struck(p1_q[tgt_idx]);
				else
					p2_q[tgt_idx] <= struck(p2_q[tgt_idx]);
			end
		end
	end

	// Active ship shown on the placing player's board
	always_comb begin
		p1_board_o = p1_q;
		p2_board_o = p2_q;
		if (mode_i == battleship_pkg::MODE_PLACE) begin
			for (int i = 0; i < CELLS; i++) begin
				if (cur_mask[i]) begin
					if (turn_i)
						p2_board_o[i] = overlay(p2_q[i]);
					else
						p1_board_o[i] = overlay(p1_q[i]);
				end
			end
		end
	end

endmodule

// File: source/fleet_tracker.sv
`timescale 1ns/1ps

module fleet_tracker #(
	parameter int BOARD_DIM = battleship_pkg::DEFAULT_BOARD_DIM
) (
	input  logic                                           btnC,
	input  logic                                           rst_n_i,
	input  logic                                           commit_i,
	input  battleship_pkg::ship_pos_t                      cursor_pos_i,
	input  logic [2:0]                                     ship_idx_i,
	input  logic                                           turn_i,
	input  battleship_pkg::mode_t                          mode_i,
	input  battleship_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0] p1_board_i,
	input  battleship_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0] p2_board_i,
	output battleship_pkg::ship_cnt_t                      p1_ships_o,
	output battleship_pkg::ship_cnt_t                      p2_ships_o
);

	localparam int CELLS = BOARD_DIM * BOARD_DIM;
	localparam int SHIPS = battleship_pkg::SHIPS_PER_PLAYER;
	localparam int FLEET = 2 * SHIPS;

	typedef battleship_pkg::cell_t [CELLS-1:0] board_t;

	// Slots 0 to 4 are player 1, 5 to 9 player 2
	battleship_pkg::ship_pos_t [FLEET-1:0] fleet_q;
	logic [FLEET-1:0]                      placed_q;
	logic [FLEET-1:0]                      afloat;
	int                                    slot;

	// Afloat while any cell is still an unhit ship cell
	function automatic logic ship_afloat(battleship_pkg::ship_pos_t pos, board_t board);
		int   idx;
		logic found;
		found = 1'b0;
		for (int k = 0; k < battleship_pkg::MAX_SHIP_LEN; k++) begin
			idx = battleship_pkg::ship_cell_index(pos, k, BOARD_DIM);
			if (k < int'(pos.len) && idx < CELLS && board[idx] == battleship_pkg::CELL_SHIP)
				found = 1'b1;
		end
		return found;
	endfunction

	function automatic battleship_pkg::ship_cnt_t count_ships(logic [SHIPS-1:0] flags);
		battleship_pkg::ship_cnt_t cnt;
		cnt = '0;
		for (int s = 0; s < SHIPS; s++)
			cnt = cnt + battleship_pkg::ship_cnt_t'(flags[s]);
		return cnt;
	endfunction

	assign slot = int'(turn_i) * SHIPS + int'(ship_idx_i);

	always_ff @(posedge btnC) begin
		if (!rst_n_i) begin
			placed_q <= '0;
		end else if (commit_i) begin
			placed_q[slot] <= 1'b1;
		end
	end

	// Ship record stored at the placing player's slot
	always_ff @(posedge btnC) begin
		if (commit_i)
			fleet_q[slot] <= cursor_pos_i;
	end

	always_comb begin
		for (int s = 0; s < SHIPS; s++) begin
			afloat[s] = placed_q[s] && ship_afloat(fleet_q[s], p1_board_i);
			afloat[s+SHIPS] = placed_q[s+SHIPS] && ship_afloat(fleet_q[s+SHIPS], p2_board_i);
		end
	end

	// Placement counts ships committed, battle counts ships afloat
	assign p1_ships_o = (mode_i == battleship_pkg::MODE_PLACE) ?
		count_ships(placed_q[SHIPS-1:0]) : count_ships(afloat[SHIPS-1:0]);
	assign p2_ships_o = (mode_i == battleship_pkg::MODE_PLACE) ?
		count_ships(placed_q[FLEET-1:SHIPS]) : count_ships(afloat[FLEET-1:SHIPS]);

endmodule

// File: source/battleship_top.sv
`timescale 1ns/1ps

module battleship_top #(
	parameter int BOARD_DIM = battleship_pkg::DEFAULT_BOARD_DIM
) (
	input  logic                                           btnC,
	input  logic                                           rst_n_i,
	input  battleship_pkg::move_cmd_t                      move_i,
	input  logic                                           orient_i,
	input  logic                                           place_i,
	input  logic                                           fire_i,
	input  logic [7:0]                                     target_i,
	output battleship_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0] p1_board_o,
	output battleship_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0] p2_board_o,
	output battleship_pkg::ship_cnt_t                      p1_ships_o,
	output battleship_pkg::ship_cnt_t                      p2_ships_o,
	output battleship_pkg::mode_t                          mode_o,
	output logic                                           turn_o
);

	battleship_pkg::ship_pos_t cursor_pos;
	logic                      overlap;
	logic                      commit;
	logic                      strike;
	logic [2:0]                ship_idx;

	// Mode, turn and strobe acceptance
	game_ctrl #(.BOARD_DIM(BOARD_DIM)) u_game_ctrl (
		.btnC       (btnC),
		.rst_n_i    (rst_n_i),
		.place_i    (place_i),
		.fire_i     (fire_i),
		.target_i   (target_i),
		.overlap_i  (overlap),
		.commit_o   (commit),
		.strike_o   (strike),
		.ship_idx_o (ship_idx),
		.turn_o     (turn_o),
		.mode_o     (mode_o)
	);

	ship_cursor #(.BOARD_DIM(BOARD_DIM)) u_ship_cursor (
		.btnC         (btnC),
		.rst_n_i      (rst_n_i),
		.move_i       (move_i),
		.orient_i     (orient_i),
		.commit_i     (commit),
		.ship_idx_i   (ship_idx),
		.mode_i       (mode_o),
		.cursor_pos_o (cursor_pos)
	);

	board_store #(.BOARD_DIM(BOARD_DIM)) u_board_store (
		.btnC         (btnC),
		.rst_n_i      (rst_n_i),
		.cursor_pos_i (cursor_pos),
		.commit_i     (commit),
		.strike_i     (strike),
		.target_i     (target_i),
		.turn_i       (turn_o),
		.mode_i       (mode_o),
		.overlap_o    (overlap),
		.p1_board_o   (p1_board_o),
		.p2_board_o   (p2_board_o)
	);

	// Counts read the displayed boards, which carry no overlay in battle
	fleet_tracker #(.BOARD_DIM(BOARD_DIM)) u_fleet_tracker (
		.btnC         (btnC),
		.rst_n_i      (rst_n_i),
		.commit_i     (commit),
		.cursor_pos_i (cursor_pos),
		.ship_idx_i   (ship_idx),
		.turn_i       (turn_o),
		.mode_i       (mode_o),
		.p1_board_i   (p1_board_o),
		.p2_board_i   (p2_board_o),
		.p1_ships_o   (p1_ships_o),
		.p2_ships_o   (p2_ships_o)
	);

endmodule

// File: bench/battleship_assertions.sv
`timescale 1ns/1ps

module battleship_assertions (
	input logic                  btnC,
	input logic                  rst_n_i,
	input logic                  commit_i,
	input logic                  strike_i,
	input logic                  turn_i,
	input battleship_pkg::mode_t mode_i
);

	// Read by the testbench at the end of the run
	int unsigned fail_count = 0;

	commit_strike_excl: assert property (@(posedge btnC) disable iff (!rst_n_i)
		!(commit_i && strike_i))
	else begin
		fail_count++;
		$error("commit and strike high in the same cycle");
	end

	// Only reset leaves battle
	battle_holds: assert property (@(posedge btnC) disable iff (!rst_n_i)
		(mode_i == battleship_pkg::MODE_BATTLE) |=> (mode_i == battleship_pkg::MODE_BATTLE))
	else begin
		fail_count++;
		$error("mode left battle without reset");
	end

	turn_after_event: assert property (@(posedge btnC) disable iff (!rst_n_i)
		$changed(turn_i) |-> $past(commit_i || strike_i))
	else begin
		fail_count++;
		$error("turn changed without a commit or strike");
	end

endmodule

bind game_ctrl battleship_assertions u_ctrl_checks (
	.btnC     (btnC),
	.rst_n_i  (rst_n_i),
	.commit_i (commit_o),
	.strike_i (strike_o),
	.turn_i   (turn_o),
	.mode_i   (mode_o)
);

// File: bench/battleship_tb.sv
`timescale 1ns/1ps

module battleship_tb;

	localparam int DIM = 10;
	localparam int CELLS = DIM * DIM;

	localparam battleship_pkg::move_cmd_t MV_LEFT = 4'b1000;
	localparam battleship_pkg::move_cmd_t MV_RIGHT = 4'b0100;
	localparam battleship_pkg::move_cmd_t MV_UP = 4'b0010;
	localparam battleship_pkg::move_cmd_t MV_DOWN = 4'b0001;

	logic                              btnC;
	logic                              rst_n_i;
	battleship_pkg::move_cmd_t         move_i;
	logic                              orient_i;
	logic                              place_i;
	logic                              fire_i;
	logic [7:0]                        target_i;
	battleship_pkg::cell_t [CELLS-1:0] p1_board;
	battleship_pkg::cell_t [CELLS-1:0] p2_board;
	battleship_pkg::ship_cnt_t         p1_ships;
	battleship_pkg::ship_cnt_t         p2_ships;
	battleship_pkg::mode_t             mode;
	logic                              turn;

	int          checks;
	int          errors;
	int unsigned assert_fails;
	bit          exp_turn;
	// Where the testbench put each ship, all horizontal
	int          ship_row [2][5];
	int          ship_col [2][5];
	int          noted [2];

	battleship_top #(.BOARD_DIM(DIM)) u_dut (
		.btnC       (btnC),
		.rst_n_i    (rst_n_i),
		.move_i     (move_i),
		.orient_i   (orient_i),
		.place_i    (place_i),
		.fire_i     (fire_i),
		.target_i   (target_i),
		.p1_board_o (p1_board),
		.p2_board_o (p2_board),
		.p1_ships_o (p1_ships),
		.p2_ships_o (p2_ships),
		.mode_o     (mode),
		.turn_o     (turn)
	);

	always #4 btnC = ~btnC;

	////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////

	function automatic int ship_length(input int idx);
		case (idx)
			0: return 5;
			1: return 4;
			2, 3: return 3;
			default: return 2;
		endcase
	endfunction

	function automatic bit fleet_cell(input int p, input int r, input int c);
		bit found;
		found = 1'b0;
		for (int s = 0; s < noted[p]; s++) begin
			if (r == ship_row[p][s] && c >= ship_col[p][s] &&
				c < ship_col[p][s] + ship_length(s))
				found = 1'b1;
		end
		return found;
	endfunction

	// Anchor pulled back when the turned ship overhangs
	function automatic int clamp_anchor(input int a, input int len);
		return (a + len > DIM) ? DIM - len : a;
	endfunction

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Player 1 board holds only the cursor
	task automatic expect_cursor(input string name, input int r, input int c,
		input bit vert, input int len);
		int rr;
		int cc;
		bit on;
		for (int i = 0; i < CELLS; i++) begin
			rr = i / DIM;
			cc = i % DIM;
			if (vert)
				on = (cc == c) && (rr >= r) && (rr < r + len);
			else
				on = (rr == r) && (cc >= c) && (cc < c + len);
			compare($sformatf("%s cell %0d", name, i),
				on ? battleship_pkg::CELL_ACTIVE : battleship_pkg::CELL_BLANK, p1_board[i]);
		end
	endtask

	task automatic move_once(input battleship_pkg::move_cmd_t m);
		@(posedge btnC);
		move_i <= m;
		@(posedge btnC);
		move_i <= '0;
		@(negedge btnC);
	endtask

	task automatic move_repeat(input battleship_pkg::move_cmd_t m, input int n);
		for (int k = 0; k < n; k++)
			move_once(m);
	endtask

	task automatic place_ship();
		@(posedge btnC);
		place_i <= 1'b1;
		@(posedge btnC);
		place_i <= 1'b0;
		@(negedge btnC);
	endtask

	task automatic fire_at(input logic [7:0] tgt);
		@(posedge btnC);
		target_i <= tgt;
		fire_i <= 1'b1;
		@(posedge btnC);
		fire_i <= 1'b0;
		@(negedge btnC);
	endtask

	// Rotation lands on the edge after orient_i is seen
	task automatic set_orient(input bit v);
		@(posedge btnC);
		orient_i <= v;
		@(posedge btnC);
		@(negedge btnC);
	endtask

	task automatic wait_for_mode(input battleship_pkg::mode_t m, input int limit);
		int n;
		n = 0;
		while (mode != m && n < limit) begin
			@(negedge btnC);
			n++;
		end
		if (mode != m) begin
			errors++;
			$display("Timeout: mode did not reach %0d within %0d cycles", m, limit);
		end
	endtask

	task automatic note_ship(input int p, input int idx, input int r, input int c);
		ship_row[p][idx] = r;
		ship_col[p][idx] = c;
		noted[p] = idx + 1;
	endtask

	// Cursor starts from its respawn corner
	task automatic place_at(input int p, input int idx, input int r, input int c);
		move_repeat(MV_DOWN, r);
		move_repeat(MV_RIGHT, c);
		place_ship();
		note_ship(p, idx, r, c);
	endtask

	task automatic strike(input string name, input int r, input int c);
		int victim;
		bit ship;
		victim = exp_turn ? 0 : 1;
		ship = fleet_cell(victim, r, c);
		fire_at(8'(r * 16 + c));
		exp_turn = !exp_turn;
		compare(name, ship ? battleship_pkg::CELL_HIT : battleship_pkg::CELL_MISS,
			victim ? p2_board[r*DIM+c] : p1_board[r*DIM+c]);
		compare({name, " turn"}, exp_turn, turn);
	endtask

	task automatic random_miss(input string name);
		int r;
		int c;
		int tries;
		tries = 0;
		r = int'($urandom % DIM);
		c = int'($urandom % DIM);
		while (fleet_cell(exp_turn ? 0 : 1, r, c) && tries < 100) begin
			r = int'($urandom % DIM);
			c = int'($urandom % DIM);
			tries++;
		end
		strike(name, r, c);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic reset_state();
		expect_cursor("reset p1", 0, 0, 1'b0, 5);
		for (int i = 0; i < CELLS; i++)
			compare("reset p2", battleship_pkg::CELL_BLANK, p2_board[i]);
		compare("reset p1 count", 0, p1_ships);
		compare("reset p2 count", 0, p2_ships);
		compare("reset mode", battleship_pkg::MODE_PLACE, mode);
		compare("reset turn", 0, turn);
	endtask

	task automatic move_and_rotate();
		move_once(MV_LEFT);
		expect_cursor("left at edge", 0, 0, 1'b0, 5);
		move_once(MV_UP);
		expect_cursor("up at edge", 0, 0, 1'b0, 5);
		move_once(MV_RIGHT);
		expect_cursor("right", 0, 1, 1'b0, 5);
		move_once(MV_DOWN);
		expect_cursor("down", 1, 1, 1'b0, 5);
		move_repeat(MV_RIGHT, 4);
		expect_cursor("touch col 9", 1, 5, 1'b0, 5);
		move_once(MV_RIGHT);
		expect_cursor("right blocked", 1, 5, 1'b0, 5);
		move_repeat(MV_DOWN, 6);
		set_orient(1'b1);
		expect_cursor("raise orient", clamp_anchor(7, 5), 5, 1'b1, 5);
		move_repeat(MV_RIGHT, 2);
		expect_cursor("vertical col 7", 5, 7, 1'b1, 5);
		set_orient(1'b0);
		expect_cursor("lower orient", 5, clamp_anchor(7, 5), 1'b0, 5);
	endtask

	task automatic overlap_handling();
		place_ship();
		note_ship(0, 0, 5, 5);
		compare("first ship count", 1, p1_ships);
		// Length 4 over columns 2 to 5 of row 5
		move_repeat(MV_DOWN, 5);
		move_repeat(MV_RIGHT, 2);
		compare("overlap cell", battleship_pkg::CELL_OVERLAP, p1_board[5*DIM+5]);
		compare("active cell", battleship_pkg::CELL_ACTIVE, p1_board[5*DIM+2]);
		place_ship();
		compare("blocked place count", 1, p1_ships);
		move_once(MV_DOWN);
		place_ship();
		note_ship(0, 1, 6, 2);
		compare("second ship count", 2, p1_ships);
		for (int c = 2; c < 6; c++)
			compare("second ship cell", battleship_pkg::CELL_SHIP, p1_board[6*DIM+c]);
	endtask

	task automatic full_placement();
		place_at(0, 2, 0, 0);
		place_at(0, 3, 1, 0);
		place_at(0, 4, 2, 0);
		compare("p1 fleet count", 5, p1_ships);
		compare("turn after p1 fleet", 1, turn);
		for (int s = 0; s < 4; s++)
			place_at(1, s, 2 * s, 0);
		place_at(1, 4, 8, 3);
		wait_for_mode(battleship_pkg::MODE_BATTLE, 4);
		exp_turn = 1'b0;
		compare("battle turn", 0, turn);
		compare("battle p1 count", 5, p1_ships);
		compare("battle p2 count", 5, p2_ships);
		for (int i = 0; i < CELLS; i++) begin
			compare("p1 fleet cell", fleet_cell(0, i / DIM, i % DIM) ?
				battleship_pkg::CELL_SHIP : battleship_pkg::CELL_BLANK, p1_board[i]);
			compare("p2 fleet cell", fleet_cell(1, i / DIM, i % DIM) ?
				battleship_pkg::CELL_SHIP : battleship_pkg::CELL_BLANK, p2_board[i]);
		end
	endtask

	task automatic strike_sequence();
		strike("first hit", 0, 2);
		random_miss("random miss");
		// Player 1 on turn, row 3 col 10 would alias cell (4,0) of player 2
		fire_at(8'hA3);
		compare("off-board row turn", exp_turn, turn);
		fire_at(8'h3A);
		compare("off-board col turn", exp_turn, turn);
		compare("off-board col cell", fleet_cell(1, 4, 0) ?
			battleship_pkg::CELL_SHIP : battleship_pkg::CELL_BLANK, p2_board[4*DIM]);
		strike("repeat hit", 0, 2);
		random_miss("second miss");
		strike("small ship first", 8, 3);
		compare("small ship damaged", 5, p2_ships);
		random_miss("third miss");
		strike("small ship second", 8, 4);
		compare("small ship sunk", 4, p2_ships);
		compare("p1 fleet intact", 5, p1_ships);
	endtask

	initial begin
		btnC = 1'b0;
		rst_n_i = 1'b0;
		move_i = '0;
		orient_i = 1'b0;
		place_i = 1'b0;
		fire_i = 1'b0;
		target_i = 8'h00;
		checks = 0;
		errors = 0;
		exp_turn = 1'b0;
		noted = '{0, 0};
		void'($urandom(32'h4069));
		repeat (2) @(posedge btnC);
		rst_n_i <= 1'b1;
		@(negedge btnC);
		reset_state();
		move_and_rotate();
		overlap_handling();
		full_placement();
		strike_sequence();
		assert_fails = u_dut.u_game_ctrl.u_ctrl_checks.fail_count;
		$display("checks %0d errors %0d assertion failures %0d", checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: all.f
source/battleship_pkg.sv
source/game_ctrl.sv
source/ship_cursor.sv
source/board_store.sv
source/fleet_tracker.sv
source/battleship_top.sv
bench/battleship_assertions.sv
bench/battleship_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= battleship_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "sim: failure reported in $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "sim: run ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
